// File: source/vec_cfg_pkg.sv
// Default sizes of the vector unit; NrLanes must be a power of two, widths derive from the sizes
package vec_cfg_pkg;

  // Default geometry, VLMAX is lanes times slots
  localparam int unsigned DefNrLanes      = 4;
  localparam int unsigned DefElemsPerLane = 4;
  localparam int unsigned DefElemWidth    = 16;

  ////////////////////
  // Width helpers
  ////////////////////

  // Index width, at least one bit
  function automatic int unsigned idx_width(input int unsigned num);
    return (num > 1) ? $clog2(num) : 1;
  endfunction

  // Width that holds every vl from 0 up to vlmax
  function automatic int unsigned vl_width(input int unsigned vlmax);
    return $clog2(vlmax + 1);
  endfunction

endpackage : vec_cfg_pkg

// File: source/vec_isa_pkg.sv
// Opcode and register field types of the vector unit; the opcode encoding uses all eight 3-bit codes
package vec_isa_pkg;

  // Number of architectural vector registers
  localparam int unsigned NrVRegs = 8;

  // Vector register number
  typedef logic [2:0] vreg_idx_t;

  ////////////////////
  // Opcodes
  ////////////////////

  // Element-wise ops write vd, the last two return a scalar
  typedef enum logic [2:0] {
    VADD_VV    = 3'd0,
    VSUB_VV    = 3'd1,
    VAND_VV    = 3'd2,
    VXOR_VV    = 3'd3,
    VADD_VX    = 3'd4,
    VMV_VX     = 3'd5,
    VREDSUM_VS = 3'd6,
    VMV_XS     = 3'd7
  } vec_op_e;

endpackage : vec_isa_pkg

// File: source/vec_cmd_if.sv
// Step command from the dispatcher; one element step per cycle, fields hold for the whole instruction
`timescale 1ns/100ps

interface vec_cmd_if #(
  parameter int unsigned NrLanes      = vec_cfg_pkg::DefNrLanes,
  parameter int unsigned ElemsPerLane = vec_cfg_pkg::DefElemsPerLane,
  parameter int unsigned ElemWidth    = vec_cfg_pkg::DefElemWidth
);
  import vec_isa_pkg::*;
  import vec_cfg_pkg::*;

  localparam int unsigned SlotWidth = idx_width(ElemsPerLane);
  localparam int unsigned VlWidth   = vl_width(NrLanes * ElemsPerLane);

  logic                 step;
  logic                 first;
  vec_op_e              op;
  vreg_idx_t            vd;
  vreg_idx_t            vs1;
  vreg_idx_t            vs2;
  logic [ElemWidth-1:0] scalar;
  logic [VlWidth-1:0]   vl;
  logic [SlotWidth-1:0] slot;

  modport ctrl (output step, first, op, vd, vs1, vs2, scalar, vl, slot);

  modport lane (input step, op, vd, vs1, vs2, scalar, vl, slot);

  modport reduce (input step, first, op, scalar);

endinterface : vec_cmd_if

// File: source/vec_dispatcher.sv
// Four-phase req/ack front end; core must hold fields while req_i is high, one instruction at a time
`timescale 1ns/100ps

module vec_dispatcher #(
  parameter int unsigned NrLanes      = vec_cfg_pkg::DefNrLanes,
  parameter int unsigned ElemsPerLane = vec_cfg_pkg::DefElemsPerLane,
  parameter int unsigned ElemWidth    = vec_cfg_pkg::DefElemWidth
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic                                                     req_i,
  input  vec_isa_pkg::vec_op_e                                     op_i,
  input  vec_isa_pkg::vreg_idx_t                                   vd_i,
  input  vec_isa_pkg::vreg_idx_t                                   vs1_i,
  input  vec_isa_pkg::vreg_idx_t                                   vs2_i,
  input  logic [ElemWidth-1:0]                                     scalar_i,
  input  logic [vec_cfg_pkg::vl_width(NrLanes*ElemsPerLane)-1:0]   vl_i,
  output logic                                                     ack_o,
  vec_cmd_if.ctrl                                                  cmd
);
  import vec_isa_pkg::*;
  import vec_cfg_pkg::*;

  localparam int unsigned Vlmax     = NrLanes * ElemsPerLane;
  localparam int unsigned VlWidth   = vl_width(Vlmax);
  localparam int unsigned SlotWidth = idx_width(ElemsPerLane);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    ACK
  } vec_state_e;

  vec_state_e           state_q, state_d;
  vec_op_e              op_q;
  vreg_idx_t            vd_q;
  vreg_idx_t            vs1_q;
  vreg_idx_t            vs2_q;
  logic [ElemWidth-1:0] scalar_q;
  logic [VlWidth-1:0]   vl_q;
  logic [SlotWidth-1:0] slot_q;
  logic                 first_q;
  logic                 ack_q;

  logic                 accept;
  logic                 last_step;
  logic [VlWidth-1:0]   vl_clamped;
  logic [SlotWidth-1:0] xs_slot;

  // vl beyond VLMAX is cut back
  assign vl_clamped = (vl_i > VlWidth'(Vlmax)) ? VlWidth'(Vlmax) : vl_i;

  // Scalar read picks one element and its index wraps at VLMAX
  assign xs_slot = SlotWidth'((scalar_i / NrLanes) % ElemsPerLane);

  assign accept = (state_q == IDLE) && req_i;

  // Extraction takes one step and other ops stop once the next slot starts at or past vl
  assign last_step = (op_q == VMV_XS) || ((slot_q + 1) * NrLanes >= vl_q);

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          // Nothing to step through when vl is zero
          state_d = ((op_i == VMV_XS) || (vl_clamped != '0)) ? RUN : ACK;
        end
      end
      RUN: begin
        if (last_step) begin
          state_d = ACK;
        end
      end
      ACK: begin
        if (!req_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      op_q     <= VADD_VV;
      vd_q     <= '0;
      vs1_q    <= '0;
      vs2_q    <= '0;
      scalar_q <= '0;
      vl_q     <= '0;
      slot_q   <= '0;
      first_q  <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      first_q <= accept;
      // One cycle after RUN so the result register has settled
      ack_q   <= (state_q == ACK) && req_i;
      if (accept) begin
        op_q     <= op_i;
        vd_q     <= vd_i;
        vs1_q    <= vs1_i;
        vs2_q    <= vs2_i;
        scalar_q <= scalar_i;
        vl_q     <= vl_clamped;
        slot_q   <= (op_i == VMV_XS) ? xs_slot : '0;
      end else if ((state_q == RUN) && !last_step) begin
        slot_q <= slot_q + 1'b1;
      end
    end
  end

  ////////////////////
  // Command outputs
  ////////////////////

  assign cmd.step   = (state_q == RUN);
  assign cmd.first  = first_q;
  assign cmd.op     = op_q;
  assign cmd.vd     = vd_q;
  assign cmd.vs1    = vs1_q;
  assign cmd.vs2    = vs2_q;
  assign cmd.scalar = scalar_q;
  assign cmd.vl     = vl_q;
  assign cmd.slot   = slot_q;

  assign ack_o = ack_q;

  // Ack only answers a request that was raised at the edge it rose on
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i))
    else $error("ack_o rose while req_i was low");

  a_op_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(req_i) |-> !$isunknown(op_i))
    else $error("op_i unknown when req_i rose");

endmodule : vec_dispatcher

// File: source/vec_lane.sv
// One lane holds elements with index mod NrLanes equal to LaneId; elements at vl and above stay as is
`timescale 1ns/100ps

module vec_lane #(
  parameter int unsigned NrLanes      = vec_cfg_pkg::DefNrLanes,
  parameter int unsigned ElemsPerLane = vec_cfg_pkg::DefElemsPerLane,
  parameter int unsigned ElemWidth    = vec_cfg_pkg::DefElemWidth,
  parameter int unsigned LaneId       = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  vec_cmd_if.lane              cmd,
  output logic [ElemWidth-1:0] lane_elem_o,
  output logic                 lane_active_o
);
  import vec_isa_pkg::*;

  // Register file slice, one slot row per register
  logic [ElemWidth-1:0] vrf_q [NrVRegs][ElemsPerLane];

  logic [ElemWidth-1:0] opnd_a;
  logic [ElemWidth-1:0] opnd_b;
  logic [ElemWidth-1:0] alu_res;
  logic                 alu_wr;
  logic                 elem_active;

  ////////////////////
  // Operand read
  ////////////////////

  assign opnd_a = vrf_q[cmd.vs1][cmd.slot];
  assign opnd_b = vrf_q[cmd.vs2][cmd.slot];

  // Global element index of this slot
  assign elem_active = (cmd.slot * NrLanes + LaneId) < cmd.vl;

  // vs2 goes to the reduction unit as is
  assign lane_elem_o   = opnd_b;
  assign lane_active_o = elem_active;

  ////////////////////
  // Element ALU
  ////////////////////

  // Results wrap at ElemWidth bits
  always_comb begin
    alu_res = opnd_b;
    alu_wr  = 1'b1;
    unique case (cmd.op)
      VADD_VV: alu_res = opnd_b + opnd_a;
      VSUB_VV: alu_res = opnd_b - opnd_a;
      VAND_VV: alu_res = opnd_b & opnd_a;
      VXOR_VV: alu_res = opnd_b ^ opnd_a;
      VADD_VX: alu_res = opnd_b + cmd.scalar;
      VMV_VX:  alu_res = cmd.scalar;
      // Scalar results, no write-back
      default: alu_wr = 1'b0;
    endcase
  end

  // Write-back at the edge that closes the step
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int s = 0; s < ElemsPerLane; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else if (cmd.step && alu_wr && elem_active) begin
      vrf_q[cmd.vd][cmd.slot] <= alu_res;
    end
  end

  // Dispatcher keeps the slot inside the slice
  a_slot_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd.step |-> (cmd.slot < ElemsPerLane))
    else $error("lane %0d got slot %0d beyond ElemsPerLane", LaneId, cmd.slot);

endmodule : vec_lane

// File: source/vec_reduce.sv
// Scalar result for sum reduction and element read; value holds from ack until the next instruction
`timescale 1ns/100ps

module vec_reduce #(
  parameter int unsigned NrLanes      = vec_cfg_pkg::DefNrLanes,
  parameter int unsigned ElemsPerLane = vec_cfg_pkg::DefElemsPerLane,
  parameter int unsigned ElemWidth    = vec_cfg_pkg::DefElemWidth
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  vec_cmd_if.reduce                         cmd,
  input  logic [NrLanes-1:0][ElemWidth-1:0] lane_elem_i,
  input  logic [NrLanes-1:0]                lane_active_i,
  output logic [ElemWidth-1:0]              resp_data_o
);
  import vec_isa_pkg::*;
  import vec_cfg_pkg::*;

  localparam int unsigned LaneIdxW = idx_width(NrLanes);
  localparam int unsigned TreeSize = 2 * NrLanes - 1;

  // Heap layout, leaves from NrLanes-1, root at 0
  logic [ElemWidth-1:0] tree_sum [TreeSize];
  logic [LaneIdxW-1:0]  xs_lane;
  logic [ElemWidth-1:0] resp_q;

  ////////////////////
  // Adder tree
  ////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_leaves
    // Inactive lanes add nothing
    assign tree_sum[NrLanes-1+l] = lane_active_i[l] ? lane_elem_i[l] : '0;
  end : gen_leaves

  for (genvar n = 0; n < NrLanes - 1; n++) begin : gen_nodes
    assign tree_sum[n] = tree_sum[2*n+1] + tree_sum[2*n+2];
  end : gen_nodes

  // Lane that owns the element picked by the scalar
  assign xs_lane = LaneIdxW'(cmd.scalar % NrLanes);

  ////////////////////
  // Result register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_q <= '0;
    end else if (cmd.op == VREDSUM_VS) begin
      // first also comes alone when vl is 0, the tree is zero then
      if (cmd.first) begin
        resp_q <= cmd.scalar + tree_sum[0];
      end else if (cmd.step) begin
        resp_q <= resp_q + tree_sum[0];
      end
    end else if ((cmd.op == VMV_XS) && cmd.step) begin
      resp_q <= lane_elem_i[xs_lane];
    end
  end

  assign resp_data_o = resp_q;

endmodule : vec_reduce

// File: source/vec_unit.sv
// Vector unit top; NrLanes must be a power of two and ElemWidth at least 8, vl is clamped to VLMAX
`timescale 1ns/100ps

module vec_unit #(
  parameter int unsigned NrLanes      = vec_cfg_pkg::DefNrLanes,
  parameter int unsigned ElemsPerLane = vec_cfg_pkg::DefElemsPerLane,
  parameter int unsigned ElemWidth    = vec_cfg_pkg::DefElemWidth
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic                                                   req_i,
  input  vec_isa_pkg::vec_op_e                                   op_i,
  input  vec_isa_pkg::vreg_idx_t                                 vd_i,
  input  vec_isa_pkg::vreg_idx_t                                 vs1_i,
  input  vec_isa_pkg::vreg_idx_t                                 vs2_i,
  input  logic [ElemWidth-1:0]                                   scalar_i,
  input  logic [vec_cfg_pkg::vl_width(NrLanes*ElemsPerLane)-1:0] vl_i,
  output logic                                                   ack_o,
  output logic [ElemWidth-1:0]                                   resp_data_o
);

  vec_cmd_if #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane),
    .ElemWidth   (ElemWidth   )
  ) cmd ();

  logic [NrLanes-1:0][ElemWidth-1:0] lane_elem;
  logic [NrLanes-1:0]                lane_active;

  ////////////////////
  // Dispatcher
  ////////////////////

  vec_dispatcher #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane),
    .ElemWidth   (ElemWidth   )
  ) i_dispatcher (
    .clk_i   (clk_i   ),
    .rst_n_i (rst_n_i ),
    .req_i   (req_i   ),
    .op_i    (op_i    ),
    .vd_i    (vd_i    ),
    .vs1_i   (vs1_i   ),
    .vs2_i   (vs2_i   ),
    .scalar_i(scalar_i),
    .vl_i    (vl_i    ),
    .ack_o   (ack_o   ),
    .cmd     (cmd     )
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes     (NrLanes     ),
      .ElemsPerLane(ElemsPerLane),
      .ElemWidth   (ElemWidth   ),
      .LaneId      (l           )
    ) i_lane (
      .clk_i        (clk_i         ),
      .rst_n_i      (rst_n_i       ),
      .cmd          (cmd           ),
      .lane_elem_o  (lane_elem[l]  ),
      .lane_active_o(lane_active[l])
    );
  end : gen_lanes

  // Scalar result path
  vec_reduce #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane),
    .ElemWidth   (ElemWidth   )
  ) i_reduce (
    .clk_i        (clk_i      ),
    .rst_n_i      (rst_n_i    ),
    .cmd          (cmd        ),
    .lane_elem_i  (lane_elem  ),
    .lane_active_i(lane_active),
    .resp_data_o  (resp_data_o)
  );

  // Elaboration checks
  if (NrLanes != 2**$clog2(NrLanes)) begin : gen_chk_lanes
    $error("NrLanes must be a power of two");
  end

  if (ElemWidth < 8) begin : gen_chk_width
    $error("ElemWidth must be at least 8");
  end

endmodule : vec_unit

// File: verif/vec_tb_clk.sv
// Free-running testbench clock; reset is released on a falling edge after ResetCycles rising edges
`timescale 1ns/100ps

module vec_tb_clk #(
  parameter int unsigned PeriodNs    = 10,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // Release away from the active edge
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

  always #(PeriodNs / 2.0) clk_o = ~clk_o;

endmodule : vec_tb_clk

// File: verif/vec_unit_tb.sv
// Testbench for vec_unit with default parameters (VLMAX 16); stimulus is a fixed table, no randomness
`timescale 1ns/100ps

module vec_unit_tb;
  import vec_isa_pkg::*;
  import vec_cfg_pkg::*;

  localparam int unsigned NrLanes      = DefNrLanes;
  localparam int unsigned ElemsPerLane = DefElemsPerLane;
  localparam int unsigned ElemWidth    = DefElemWidth;
  localparam int unsigned Vlmax        = NrLanes * ElemsPerLane;
  localparam int unsigned VlW          = vl_width(Vlmax);
  localparam int unsigned ResetCycles  = 8;
  localparam int unsigned NumRows      = 25;
  localparam int unsigned AckLimit     = Vlmax + 10;
  localparam int unsigned WatchCycles  = NumRows * (Vlmax + 10) + ResetCycles;

  typedef struct {
    vec_op_e              op;
    vreg_idx_t            vd;
    vreg_idx_t            vs1;
    vreg_idx_t            vs2;
    logic [ElemWidth-1:0] scalar;
    logic [VlW-1:0]       vl;
    bit                   check;
    logic [ElemWidth-1:0] expected;
  } test_row_t;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  vec_op_e              op;
  vreg_idx_t            vd;
  vreg_idx_t            vs1;
  vreg_idx_t            vs2;
  logic [ElemWidth-1:0] scalar;
  logic [VlW-1:0]       vl;
  logic                 ack;
  logic [ElemWidth-1:0] resp_data;

  test_row_t rows [NumRows];
  bit        in_flight;
  bit        aborted;
  int        pass_cnt;
  int        fail_cnt;
  int        hs_errors;

  vec_tb_clk #(
    .PeriodNs   (10         ),
    .ResetCycles(ResetCycles)
  ) i_clk (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  vec_unit #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane),
    .ElemWidth   (ElemWidth   )
  ) dut_i (
    .clk_i      (clk      ),
    .rst_n_i    (rst_n    ),
    .req_i      (req      ),
    .op_i       (op       ),
    .vd_i       (vd       ),
    .vs1_i      (vs1      ),
    .vs2_i      (vs2      ),
    .scalar_i   (scalar   ),
    .vl_i       (vl       ),
    .ack_o      (ack      ),
    .resp_data_o(resp_data)
  );

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic load_row(input int idx, input vec_op_e r_op, input int r_vd, input int r_vs1,
                          input int r_vs2, input int r_scalar, input int r_vl,
                          input bit r_check, input int r_expected);
    rows[idx].op       = r_op;
    rows[idx].vd       = vreg_idx_t'(r_vd);
    rows[idx].vs1      = vreg_idx_t'(r_vs1);
    rows[idx].vs2      = vreg_idx_t'(r_vs2);
    rows[idx].scalar   = ElemWidth'(r_scalar);
    rows[idx].vl       = VlW'(r_vl);
    rows[idx].check    = r_check;
    rows[idx].expected = ElemWidth'(r_expected);
  endtask

  // Columns: op, vd, vs1, vs2, scalar, vl, check, expected
  task automatic load_table();
    // Fresh register file reads as zero
    load_row(0,  VREDSUM_VS, 0, 0, 7, 0,   16, 1, 0);
    // Broadcast 5, read back from lanes 0 and 3
    load_row(1,  VMV_VX,     1, 0, 0, 5,   16, 0, 0);
    load_row(2,  VMV_XS,     0, 0, 1, 0,   0,  1, 5);
    load_row(3,  VMV_XS,     0, 0, 1, 7,   0,  1, 5);
    load_row(4,  VMV_XS,     0, 0, 1, 15,  0,  1, 5);
    load_row(5,  VMV_VX,     2, 0, 0, 3,   16, 0, 0);
    // vs2 is the left operand, so v1 op v2 is 5 op 3
    load_row(6,  VADD_VV,    3, 2, 1, 0,   16, 0, 0);
    load_row(7,  VMV_XS,     0, 0, 3, 2,   0,  1, 8);
    load_row(8,  VSUB_VV,    4, 2, 1, 0,   16, 0, 0);
    load_row(9,  VMV_XS,     0, 0, 4, 9,   0,  1, 2);
    load_row(10, VAND_VV,    5, 2, 1, 0,   16, 0, 0);
    load_row(11, VMV_XS,     0, 0, 5, 4,   0,  1, 1);
    load_row(12, VXOR_VV,    6, 2, 1, 0,   16, 0, 0);
    load_row(13, VMV_XS,     0, 0, 6, 13,  0,  1, 6);
    load_row(14, VADD_VX,    7, 0, 1, 20,  16, 0, 0);
    load_row(15, VMV_XS,     0, 0, 7, 3,   0,  1, 25);
    // 3 - 5 wraps to 0xfffe
    load_row(16, VSUB_VV,    4, 1, 2, 0,   16, 0, 0);
    load_row(17, VMV_XS,     0, 0, 4, 11,  0,  1, 16'hfffe);
    // 100 + 16 * 5, then 100 + 6 * 5, then scalar alone
    load_row(18, VREDSUM_VS, 0, 0, 1, 100, 16, 1, 180);
    load_row(19, VREDSUM_VS, 0, 0, 1, 100, 6,  1, 130);
    load_row(20, VREDSUM_VS, 0, 0, 1, 100, 0,  1, 100);
    // Only elements 0..4 take the new value
    load_row(21, VMV_VX,     1, 0, 0, 9,   5,  0, 0);
    load_row(22, VMV_XS,     0, 0, 1, 4,   0,  1, 9);
    load_row(23, VMV_XS,     0, 0, 1, 5,   0,  1, 5);
    // vl of 31 is clamped to 16, sum of sixteen 3s
    load_row(24, VREDSUM_VS, 0, 0, 2, 0,   31, 1, 48);
  endtask

  ////////////////////
  // Handshake driver
  ////////////////////

  // Looks at ack on falling edges, gives up after AckLimit cycles
  task automatic wait_for_ack(input logic level, output bit seen);
    seen = 1'b0;
    for (int c = 0; c < AckLimit; c++) begin
      @(negedge clk);
      if (ack === level) begin
        seen = 1'b1;
        break;
      end
    end
  endtask

  task automatic apply_row(input int idx, output bit timed_out);
    bit row_ok;
    bit seen;
    row_ok    = 1'b1;
    timed_out = 1'b0;
    @(negedge clk);
    op        = rows[idx].op;
    vd        = rows[idx].vd;
    vs1       = rows[idx].vs1;
    vs2       = rows[idx].vs2;
    scalar    = rows[idx].scalar;
    vl        = rows[idx].vl;
    req       = 1'b1;
    in_flight = 1'b1;
    wait_for_ack(1'b1, seen);
    if (!seen) begin
      $display("Row %0d (%s): timed out waiting for ack_o to rise", idx, rows[idx].op.name());
      timed_out = 1'b1;
      fail_cnt++;
      return;
    end
    if (rows[idx].check) begin
      assert (resp_data === rows[idx].expected) else begin
        $display("ERROR t=%0t resp_data_o expected 0x%04h actual 0x%04h",
                 $time, rows[idx].expected, resp_data);
        row_ok = 1'b0;
      end
    end
    req = 1'b0;
    wait_for_ack(1'b0, seen);
    if (!seen) begin
      $display("Row %0d (%s): timed out waiting for ack_o to fall", idx, rows[idx].op.name());
      timed_out = 1'b1;
      fail_cnt++;
      return;
    end
    in_flight = 1'b0;
    if (row_ok) begin
      pass_cnt++;
      $display("Row %0d (%s): pass", idx, rows[idx].op.name());
    end else begin
      fail_cnt++;
      $display("Row %0d (%s): fail", idx, rows[idx].op.name());
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    bit timed_out;
    req       = 1'b0;
    op        = VADD_VV;
    vd        = '0;
    vs1       = '0;
    vs2       = '0;
    scalar    = '0;
    vl        = '0;
    in_flight = 1'b0;
    aborted   = 1'b0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    hs_errors = 0;
    load_table();
    @(posedge rst_n);
    for (int i = 0; i < NumRows; i++) begin
      apply_row(i, timed_out);
      if (timed_out) begin
        aborted = 1'b1;
        break;
      end
    end
    repeat (2) @(negedge clk);
    $display("Done: %0d rows passed, %0d rows failed, %0d handshake violations%s",
             pass_cnt, fail_cnt, hs_errors, aborted ? ", run aborted" : "");
    if ((fail_cnt == 0) && (hs_errors == 0) && !aborted) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Between instructions ack must stay low
  always @(posedge clk) begin
    #1;
    if (rst_n && !in_flight) begin
      assert (!ack) else begin
        $display("Handshake violation at %0t: ack_o is high while no request is pending", $time);
        hs_errors++;
      end
    end
  end

  // Watchdog
  initial begin
    repeat (WatchCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WatchCycles);
    $display("Test FAILED");
    $finish;
  end

endmodule : vec_unit_tb

// File: compile.f
source/vec_cfg_pkg.sv
source/vec_isa_pkg.sv
source/vec_cmd_if.sv
source/vec_dispatcher.sv
source/vec_lane.sv
source/vec_reduce.sv
source/vec_unit.sv
verif/vec_tb_clk.sv
verif/vec_unit_tb.sv
